//--- hdl/uart_settings.svh
`ifndef UART_SETTINGS_SVH
`define UART_SETTINGS_SVH

// Clocks per serial bit
`define UART_BIT_CYCLES 8

// Serial channels, one slave device each
`define UART_CHANNELS 2

// Bit times to wait for the start bit of a read reply
`define UART_READ_TIMEOUT_BITS 32

// Command word: write flag, 7-bit register address, data byte
`define UART_CMD_WIDTH 16

`endif

//--- hdl/uart_cmd_pkg.sv
`default_nettype none

`include "uart_settings.svh"

package uart_cmd_pkg;

  localparam int CHAN_IDX_W = (`UART_CHANNELS > 1) ? $clog2(`UART_CHANNELS) : 1;

  // Start, 8 data bits, parity, stop
  localparam int FRAME_BITS = 11;

  // Bit 15 write flag, 14..8 address, 7..0 data
  typedef struct packed {
    logic       write;
    logic [6:0] addr;
    logic [7:0] wdata;
  } uart_cmd_t;

  typedef enum logic [3:0] {
    IDLE,
    ADDR_FRAME,
    GAP,
    DATA_FRAME,
    RX_WAIT,
    RX_FRAME,
    RESP_HOLD
  } uart_frame_state_e;

  typedef logic [CHAN_IDX_W-1:0] chan_idx_t;

endpackage

`default_nettype wire

//--- hdl/uart_resp_pkg.sv
`default_nettype none

package uart_resp_pkg;

  // Parity is checked before the stop bit
  typedef enum logic [1:0] {
    OK,
    PARITY_ERR,
    FRAME_ERR,
    TIMEOUT
  } uart_status_e;

  typedef struct packed {
    logic [7:0]   data;
    uart_status_e status;
  } uart_resp_t;

endpackage

`default_nettype wire

//--- hdl/uart_link_if.sv
`default_nettype none

// Command path from dispatcher to one channel
interface uart_cmd_if ();

  logic       valid;
  logic       ready;
  logic       write;
  logic [6:0] addr;
  logic [7:0] wdata;

  modport src (output valid, write, addr, wdata, input ready);
  modport dst (input valid, write, addr, wdata, output ready);

endinterface

// Read response from one channel to the arbiter
interface uart_resp_if
  import uart_resp_pkg::*;
();

  logic         valid;
  logic         ready;
  logic [7:0]   data;
  uart_status_e status;

  modport src (output valid, data, status, input ready);
  modport dst (input valid, data, status, output ready);

endinterface

`default_nettype wire

//--- hdl/uart_cmd_dispatch.sv
`default_nettype none

`include "uart_settings.svh"

module uart_cmd_dispatch
  import uart_cmd_pkg::*;
(
  input  wire logic                       cmd_valid,
  input  wire chan_idx_t                  cmd_chan,
  input  wire logic [`UART_CMD_WIDTH-1:0] cmd_data,
  output logic                            cmd_ready,
  uart_cmd_if.src                         chan [`UART_CHANNELS]
);

  uart_cmd_t                 cmd;
  logic [`UART_CHANNELS-1:0] ready_vec;

  assign cmd = uart_cmd_t'(cmd_data);

  // Fields go to every channel, only the selected one sees valid
  for (genvar i = 0; i < `UART_CHANNELS; i++)
  begin : g_chan
    assign chan[i].valid = cmd_valid && (cmd_chan == chan_idx_t'(i));
    assign chan[i].write = cmd.write;
    assign chan[i].addr  = cmd.addr;
    assign chan[i].wdata = cmd.wdata;

    assign ready_vec[i] = chan[i].ready;
  end

  // Ready follows the selected channel even without valid
  assign cmd_ready = ready_vec[cmd_chan];

endmodule

`default_nettype wire

//--- hdl/uart_channel.sv
`default_nettype none

`include "uart_settings.svh"

module uart_channel
  import uart_cmd_pkg::*;
  import uart_resp_pkg::*;
(
  input  wire logic clk,
  input  wire logic rst_n,
  input  wire logic rx,
  output logic      tx,
  uart_cmd_if.dst   cmd,
  uart_resp_if.src  resp
);

  localparam int BIT_CYCLES = `UART_BIT_CYCLES;
  localparam int BAUD_W     = $clog2(BIT_CYCLES);
  // Two cycles of synchronizer delay already sit in front of the sample
  localparam int HALF       = (BIT_CYCLES >= 4) ? BIT_CYCLES / 2 - 2 : 0;
  localparam int TMO_W      = $clog2(`UART_READ_TIMEOUT_BITS + 1);

  uart_frame_state_e state;
  logic [BAUD_W-1:0] baud_cnt;
  logic [3:0]        bit_cnt;
  logic [TMO_W-1:0]  tmo_cnt;
  logic              rx_meta;
  logic              rx_s;

  logic              write_q;
  logic [7:0]        wdata_q;
  logic [7:0]        byte_q;
  logic              par_q;
  logic [7:0]        rx_byte;
  logic              rx_par;
  uart_resp_t        resp_q;

  logic              bit_end;
  logic              mid_bit;
  logic              frame_last;
  logic              tmo_last;

  assign bit_end    = baud_cnt == BAUD_W'(BIT_CYCLES - 1);
  assign mid_bit    = baud_cnt == BAUD_W'(HALF);
  assign frame_last = bit_cnt == 4'(FRAME_BITS - 1);
  assign tmo_last   = tmo_cnt == TMO_W'(`UART_READ_TIMEOUT_BITS - 1);

  assign cmd.ready   = state == IDLE;
  assign resp.valid  = state == RESP_HOLD;
  assign resp.data   = resp_q.data;
  assign resp.status = resp_q.status;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rx_meta <= 1'b1;
      rx_s    <= 1'b1;
    end
    else
    begin
      rx_meta <= rx;
      rx_s    <= rx_meta;
    end
  end

  // Control: state, line driver and counters
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state    <= IDLE;
      tx       <= 1'b1;
      baud_cnt <= '0;
      bit_cnt  <= '0;
      tmo_cnt  <= '0;
    end
    else
    begin
      if (state == IDLE || state == RESP_HOLD || bit_end)
        baud_cnt <= '0;
      else
        baud_cnt <= baud_cnt + 1'b1;

      case (state)
        IDLE:
          if (cmd.valid)
          begin
            state   <= ADDR_FRAME;
            tx      <= 1'b0;
            bit_cnt <= '0;
          end
        ADDR_FRAME, DATA_FRAME:
          if (bit_end)
          begin
            bit_cnt <= bit_cnt + 1'b1;
            if (frame_last)
            begin
              if (state == DATA_FRAME)
                state <= IDLE;
              else if (write_q)
                state <= GAP;
              else
              begin
                state   <= RX_WAIT;
                tmo_cnt <= '0;
              end
            end
            else if (bit_cnt < 4'd8)
              tx <= byte_q[0];
            else if (bit_cnt == 4'd8)
              tx <= par_q;
            else
              tx <= 1'b1;
          end
        GAP:
          if (bit_end)
          begin
            state   <= DATA_FRAME;
            tx      <= 1'b0;
            bit_cnt <= '0;
          end
        RX_WAIT:
          if (!rx_s)
          begin
            // Realign the bit clock to the falling edge
            state    <= RX_FRAME;
            baud_cnt <= '0;
            bit_cnt  <= '0;
          end
          else if (bit_end)
          begin
            tmo_cnt <= tmo_cnt + 1'b1;
            if (tmo_last)
              state <= RESP_HOLD;
          end
        RX_FRAME:
          if (mid_bit && frame_last)
            state <= RESP_HOLD;
          else if (bit_end)
            bit_cnt <= bit_cnt + 1'b1;
        RESP_HOLD:
          if (resp.ready)
            state <= IDLE;
        default:
          state <= IDLE;
      endcase
    end
  end

  // Datapath: shift registers, parity and the held response
  always_ff @(posedge clk)
  begin
    case (state)
      IDLE:
        if (cmd.valid)
        begin
          write_q <= cmd.write;
          wdata_q <= cmd.wdata;
          byte_q  <= {cmd.write, cmd.addr};
          par_q   <= 1'b0;
        end
      ADDR_FRAME, DATA_FRAME:
        if (bit_end && bit_cnt < 4'd8)
        begin
          byte_q <= {1'b0, byte_q[7:1]};
          par_q  <= par_q ^ byte_q[0];
        end
      GAP:
        if (bit_end)
        begin
          byte_q <= wdata_q;
          par_q  <= 1'b0;
        end
      RX_WAIT:
        if (!rx_s)
          rx_par <= 1'b0;
        else if (bit_end && tmo_last)
        begin
          resp_q.data   <= 8'h00;
          resp_q.status <= TIMEOUT;
        end
      RX_FRAME:
        if (mid_bit)
        begin
          if (frame_last)
          begin
            resp_q.data <= rx_byte;
            if (rx_par)
              resp_q.status <= PARITY_ERR;
            else if (!rx_s)
              resp_q.status <= FRAME_ERR;
            else
              resp_q.status <= OK;
          end
          else if (bit_cnt != 4'd0)
            rx_par <= rx_par ^ rx_s;
          // Data arrives LSB first
          if (bit_cnt >= 4'd1 && bit_cnt <= 4'd8)
            rx_byte <= {rx_s, rx_byte[7:1]};
        end
      default:
        ;
    endcase
  end

endmodule

`default_nettype wire

//--- hdl/uart_resp_arbiter.sv
`default_nettype none

`include "uart_settings.svh"

module uart_resp_arbiter
  import uart_cmd_pkg::*;
  import uart_resp_pkg::*;
(
  input  wire logic   clk,
  input  wire logic   rst_n,
  input  wire logic   read_ready,
  uart_resp_if.dst    chan [`UART_CHANNELS],
  output logic        read_valid,
  output logic [7:0]  read_data,
  output uart_status_e read_status,
  output chan_idx_t   read_chan
);

  localparam int N = `UART_CHANNELS;

  logic [N-1:0] valid_vec;
  logic [7:0]   data_vec [N];
  uart_status_e status_vec [N];
  chan_idx_t    ptr;
  chan_idx_t    search;
  chan_idx_t    grant;
  chan_idx_t    grant_q;
  logic         locked;

  for (genvar i = 0; i < N; i++)
  begin : g_chan
    assign valid_vec[i]  = chan[i].valid;
    assign data_vec[i]   = chan[i].data;
    assign status_vec[i] = chan[i].status;
    assign chan[i].ready = read_valid && read_ready && (grant == chan_idx_t'(i));
  end

  // Walk backwards so the nearest valid channel at or after ptr wins
  always_comb
  begin
    search = ptr;
    for (int k = N - 1; k >= 0; k--)
    begin
      if (valid_vec[(int'(ptr) + k) % N])
        search = chan_idx_t'((int'(ptr) + k) % N);
    end
  end

  // A stalled grant stays put until read_ready
  assign grant = locked ? grant_q : search;

  assign read_valid  = valid_vec[grant];
  assign read_data   = data_vec[grant];
  assign read_status = status_vec[grant];
  assign read_chan   = grant;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      ptr     <= '0;
      grant_q <= '0;
      locked  <= 1'b0;
    end
    else
    begin
      locked  <= read_valid && !read_ready;
      grant_q <= grant;
      if (read_valid && read_ready)
        ptr <= chan_idx_t'((int'(grant) + 1) % N);
    end
  end

endmodule

`default_nettype wire

//--- hdl/uart_master_top.sv
`default_nettype none

`include "uart_settings.svh"

module uart_master_top
  import uart_cmd_pkg::*;
  import uart_resp_pkg::*;
(
  input  wire logic                       clk,
  input  wire logic                       rst_n,

  input  wire logic                       cmd_valid,
  output logic                            cmd_ready,
  input  wire chan_idx_t                  cmd_chan,
  input  wire logic [`UART_CMD_WIDTH-1:0] cmd_data,

  output logic                            read_valid,
  input  wire logic                       read_ready,
  output logic [7:0]                      read_data,
  output uart_status_e                    read_status,
  output chan_idx_t                       read_chan,

  output logic [`UART_CHANNELS-1:0]       tx,
  input  wire logic [`UART_CHANNELS-1:0]  rx
);

  uart_cmd_if  cmd_if  [`UART_CHANNELS] ();
  uart_resp_if resp_if [`UART_CHANNELS] ();

  uart_cmd_dispatch u_dispatch (
    .cmd_valid (cmd_valid),
    .cmd_chan  (cmd_chan),
    .cmd_data  (cmd_data),
    .cmd_ready (cmd_ready),
    .chan      (cmd_if)
  );

  // One engine per serial line
  for (genvar i = 0; i < `UART_CHANNELS; i++)
  begin : g_chan
    uart_channel u_channel (
      .clk   (clk),
      .rst_n (rst_n),
      .rx    (rx[i]),
      .tx    (tx[i]),
      .cmd   (cmd_if[i]),
      .resp  (resp_if[i])
    );
  end

  uart_resp_arbiter u_arbiter (
    .clk         (clk),
    .rst_n       (rst_n),
    .read_ready  (read_ready),
    .chan        (resp_if),
    .read_valid  (read_valid),
    .read_data   (read_data),
    .read_status (read_status),
    .read_chan   (read_chan)
  );

endmodule

`default_nettype wire

//--- verification/uart_master_chk.sv
`default_nettype none

`include "uart_settings.svh"

module uart_master_chk
  import uart_cmd_pkg::*;
  import uart_resp_pkg::*;
(
  input wire logic                      clk,
  input wire logic                      rst_n,
  input wire logic                      read_valid,
  input wire logic                      read_ready,
  input wire logic [7:0]                read_data,
  input wire uart_status_e              read_status,
  input wire chan_idx_t                 read_chan,
  input wire logic [`UART_CHANNELS-1:0] tx
);

  // A stalled response keeps valid and all of its fields
  property hold_until_ready;
    @(posedge clk) disable iff (!rst_n)
      read_valid && !read_ready |=> read_valid && $stable(read_data)
        && $stable(read_status) && $stable(read_chan);
  endproperty

  property tx_idle_in_reset;
    @(posedge clk) !rst_n |-> tx == '1;
  endproperty

  property no_read_in_reset;
    @(posedge clk) !rst_n |-> !read_valid;
  endproperty

  a_hold: assert property (hold_until_ready)
    else $error("read stream dropped or changed before read_ready");

  a_tx_reset: assert property (tx_idle_in_reset)
    else $error("tx not idle during reset");

  a_valid_reset: assert property (no_read_in_reset)
    else $error("read_valid high during reset");

endmodule

`default_nettype wire

//--- verification/uart_master_tb.sv
`default_nettype none

`include "uart_settings.svh"

module uart_master_tb
  import uart_cmd_pkg::*;
  import uart_resp_pkg::*;
();

  localparam int          CH          = `UART_CHANNELS;
  localparam int          BIT         = `UART_BIT_CYCLES;
  localparam int          NUM_CMDS    = 80;
  localparam int          READY_LIMIT = 4000;
  localparam int          IDLE_LIMIT  = 200000;
  localparam logic [31:0] SEED        = 32'h6c56_ac06;

  logic                       clk;
  logic                       rst_n;
  logic                       cmd_valid;
  logic                       cmd_ready;
  chan_idx_t                  cmd_chan;
  logic [`UART_CMD_WIDTH-1:0] cmd_data;
  logic                       read_valid;
  logic                       read_ready;
  logic [7:0]                 read_data;
  uart_status_e               read_status;
  chan_idx_t                  read_chan;
  logic [CH-1:0]              tx;
  wire  [CH-1:0]              rx;

  logic [31:0] stim_seed;
  logic [31:0] rdy_seed;
  int          mismatch_cnt;
  int          fail_cnt;
  bit          finished;
  bit          abort;

  // Reply modes: 0 clean, 1 parity flipped, 2 stop bit low, 3 no reply
  logic [15:0] sent_q [CH][$];
  int          mode_q [CH][$];
  logic [9:0]  exp_q [CH][$];
  logic [7:0]  ref_regs [CH][128];

  uart_master_top u_dut (
    .clk         (clk),
    .rst_n       (rst_n),
    .cmd_valid   (cmd_valid),
    .cmd_ready   (cmd_ready),
    .cmd_chan    (cmd_chan),
    .cmd_data    (cmd_data),
    .read_valid  (read_valid),
    .read_ready  (read_ready),
    .read_data   (read_data),
    .read_status (read_status),
    .read_chan   (read_chan),
    .tx          (tx),
    .rx          (rx)
  );

  bind uart_master_top uart_master_chk u_chk (
    .clk         (clk),
    .rst_n       (rst_n),
    .read_valid  (read_valid),
    .read_ready  (read_ready),
    .read_data   (read_data),
    .read_status (read_status),
    .read_chan   (read_chan),
    .tx          (tx)
  );

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Odd multiplier keeps every address distinct
  function automatic logic [7:0] fill_value(input int ch, input int a);
    return 8'(a * 37 + ch * 101 + 11);
  endfunction

  task automatic log_mismatch(input string sig, input logic [31:0] expected,
                              input logic [31:0] actual);
    mismatch_cnt++;
    $display("MISMATCH time=%0t signal=%s expected=%0h actual=%0h",
             $time, sig, expected, actual);
  endtask

  task automatic count_failure(input string msg);
    fail_cnt++;
    $display("ERROR time=%0t %s", $time, msg);
  endtask

  task automatic compare_frame(input string line_name, input logic [9:0] bits,
                               input logic [7:0] expected);
    assert (bits[7:0] == expected)
    else log_mismatch(line_name, 32'(expected), 32'(bits[7:0]));
    assert (^bits[8:0] == 1'b0)
    else count_failure($sformatf("odd parity in a frame on %s", line_name));
    assert (bits[9] == 1'b1)
    else count_failure($sformatf("stop bit low in a frame on %s", line_name));
  endtask

  task automatic wait_cmd_ready(input int ch);
    int cnt;
    cnt = 0;
    while (cnt < READY_LIMIT)
    begin
      @(negedge clk);
      if (cmd_ready)
        break;
      cnt++;
    end
    if (cnt == READY_LIMIT)
    begin
      count_failure($sformatf("cmd_ready never rose on channel %0d", ch));
      abort = 1'b1;
    end
  endtask

  task automatic verify_reset_state();
    @(negedge clk);
    assert (tx === '1)
    else log_mismatch("tx", 32'((1 << CH) - 1), 32'(tx));
    assert (read_valid === 1'b0)
    else log_mismatch("read_valid", 32'd0, 32'(read_valid));
    for (int c = 0; c < CH; c++)
    begin
      @(posedge clk);
      #1 cmd_chan = chan_idx_t'(c);
      @(negedge clk);
      assert (cmd_ready === 1'b1)
      else log_mismatch($sformatf("cmd_ready[%0d]", c), 32'd1, 32'(cmd_ready));
    end
  endtask

  task automatic issue_cmd(input int n);
    int         ch;
    logic       wr;
    logic [6:0] addr;
    logic [7:0] wdata;
    int         mode;
    stim_seed = lcg_step(stim_seed);
    ch        = int'(stim_seed[23:16]) % CH;
    wr        = stim_seed[29];
    addr      = stim_seed[14:8];
    stim_seed = lcg_step(stim_seed);
    wdata     = stim_seed[23:16];
    mode      = (stim_seed[30:28] < 3'd5) ? 0 : int'(stim_seed[30:28]) - 4;
    // Open with one read of each reply kind on channel 0
    if (n < 4)
    begin
      ch   = 0;
      wr   = 1'b0;
      mode = n;
    end
    @(posedge clk);
    #1;
    cmd_chan  = chan_idx_t'(ch);
    cmd_data  = {wr, addr, wdata};
    cmd_valid = 1'b1;
    wait_cmd_ready(ch);
    if (!abort)
    begin
      assert (exp_q[ch].size() == 0)
      else count_failure($sformatf("cmd_ready high on channel %0d before its response left", ch));
      sent_q[ch].push_back(cmd_data);
      if (wr)
        ref_regs[ch][addr] = wdata;
      else
      begin
        mode_q[ch].push_back(mode);
        case (mode)
          0: exp_q[ch].push_back({ref_regs[ch][addr], OK});
          1: exp_q[ch].push_back({ref_regs[ch][addr], PARITY_ERR});
          2: exp_q[ch].push_back({ref_regs[ch][addr], FRAME_ERR});
          default: exp_q[ch].push_back({8'h00, TIMEOUT});
        endcase
      end
    end
    @(posedge clk);
    #1 cmd_valid = 1'b0;
  endtask

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  initial
  begin
    read_ready = 1'b0;
    rdy_seed   = SEED ^ 32'h5a5a_5a5a;
    forever
    begin
      @(posedge clk);
      #1;
      rdy_seed   = lcg_step(rdy_seed);
      read_ready = rdy_seed[31:30] != 2'b00;
    end
  end

  // Scoreboard on the merged read stream
  initial
  begin
    logic [9:0]   exp;
    logic         stall;
    logic [7:0]   held_data;
    uart_status_e held_status;
    chan_idx_t    held_chan;
    stall = 1'b0;
    forever
    begin
      @(negedge clk);
      if (rst_n)
      begin
        if (stall)
          assert (read_valid && read_data == held_data && read_status == held_status
                  && read_chan == held_chan)
          else count_failure("read stream changed while read_ready was low");
        stall       = read_valid && !read_ready;
        held_data   = read_data;
        held_status = read_status;
        held_chan   = read_chan;
        if (read_valid && read_ready)
        begin
          if (exp_q[read_chan].size() == 0)
            count_failure($sformatf("response on channel %0d with no read pending", read_chan));
          else
          begin
            exp = exp_q[read_chan].pop_front();
            assert (read_status == uart_status_e'(exp[1:0]))
            else log_mismatch("read_status", 32'(exp[1:0]), 32'(read_status));
            if (exp[1:0] == OK || exp[1:0] == TIMEOUT)
              assert (read_data == exp[9:2])
              else log_mismatch("read_data", 32'(exp[9:2]), 32'(read_data));
          end
        end
      end
    end
  end

  // One serial device per channel with its own register file
  for (genvar g = 0; g < CH; g++)
  begin : g_dev
    logic       line;
    logic [7:0] dev_regs [128];

    assign rx[g] = line;

    task automatic decode_frame(input int limit, output logic [9:0] bits,
                                output int waited, output bit got);
      waited = 0;
      bits   = '0;
      while (tx[g] !== 1'b0 && waited < limit && !finished)
      begin
        @(negedge clk);
        waited++;
      end
      got = tx[g] === 1'b0;
      if (got)
      begin
        // Move to mid-bit, then step one bit time per sample
        repeat (BIT / 2) @(negedge clk);
        for (int i = 0; i < 10; i++)
        begin
          repeat (BIT) @(negedge clk);
          bits[i] = tx[g];
        end
      end
    endtask

    task automatic drive_reply(input logic [7:0] b, input int mode);
      logic [10:0] bits;
      bits = {mode != 2, (^b) ^ (mode == 1), b, 1'b0};
      for (int i = 0; i < 11; i++)
      begin
        @(posedge clk);
        #1 line = bits[i];
        repeat (BIT - 1) @(posedge clk);
      end
      @(posedge clk);
      #1 line = 1'b1;
    endtask

    initial
    begin
      logic [9:0]  bits;
      logic [15:0] cmd;
      int          waited;
      bit          got;
      int          mode;
      line = 1'b1;
      for (int a = 0; a < 128; a++)
        dev_regs[a] = fill_value(g, a);
      waited = 0;
      while (rst_n !== 1'b1 && waited < 100)
      begin
        @(negedge clk);
        waited++;
      end
      while (!finished)
      begin
        decode_frame(IDLE_LIMIT, bits, waited, got);
        if (!got)
        begin
          if (!finished)
            count_failure($sformatf("no frame seen on tx[%0d] for too long", g));
          break;
        end
        if (sent_q[g].size() == 0)
          count_failure($sformatf("frame on tx[%0d] with no command sent", g));
        else
        begin
          cmd = sent_q[g].pop_front();
          compare_frame($sformatf("tx[%0d]", g), bits, cmd[15:8]);
          if (cmd[15])
          begin
            decode_frame(4 * BIT, bits, waited, got);
            assert (got)
            else count_failure($sformatf("write data frame missing on tx[%0d]", g));
            if (got)
            begin
              assert (waited >= BIT + BIT / 2)
              else count_failure($sformatf("gap before data frame too short on tx[%0d]", g));
              compare_frame($sformatf("tx[%0d]", g), bits, cmd[7:0]);
              dev_regs[cmd[14:8]] = bits[7:0];
            end
          end
          else
          begin
            mode = mode_q[g].pop_front();
            if (mode != 3)
            begin
              repeat (4 + 3 * g) @(posedge clk);
              drive_reply(dev_regs[cmd[14:8]], mode);
            end
          end
        end
      end
    end
  end

  initial
  begin
    rst_n        = 1'b1;
    cmd_valid    = 1'b0;
    cmd_chan     = '0;
    cmd_data     = '0;
    stim_seed    = SEED;
    mismatch_cnt = 0;
    fail_cnt     = 0;
    finished     = 1'b0;
    abort        = 1'b0;
    for (int c = 0; c < CH; c++)
      for (int a = 0; a < 128; a++)
        ref_regs[c][a] = fill_value(c, a);
    #1 rst_n = 1'b0;
    repeat (10) @(posedge clk);
    #1 rst_n = 1'b1;
    verify_reset_state();
    for (int n = 0; n < NUM_CMDS && !abort; n++)
      issue_cmd(n);
    // Every channel back in idle means every response has left
    for (int c = 0; c < CH && !abort; c++)
    begin
      @(posedge clk);
      #1 cmd_chan = chan_idx_t'(c);
      wait_cmd_ready(c);
    end
    for (int c = 0; c < CH; c++)
      assert (sent_q[c].size() == 0 && exp_q[c].size() == 0)
      else count_failure($sformatf("channel %0d ended with work still expected", c));
    finished = 1'b1;
    $display("Checks done with %0d mismatches and %0d other errors", mismatch_cnt, fail_cnt);
    if (mismatch_cnt == 0 && fail_cnt == 0)
      $display("Regression passed");
    else
      $display("Regression failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- sim.f
+incdir+hdl
hdl/uart_cmd_pkg.sv
hdl/uart_resp_pkg.sv
hdl/uart_link_if.sv
hdl/uart_cmd_dispatch.sv
hdl/uart_channel.sv
hdl/uart_resp_arbiter.sv
hdl/uart_master_top.sv
verification/uart_master_chk.sv
verification/uart_master_tb.sv

//--- Makefile
SIM        ?= verilator
TOP        ?= uart_master_tb
FILELIST   ?= sim.f
FLAGS      ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only --timing --assert -Wall
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
PASS_TEXT  ?= Regression passed

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^$(PASS_TEXT)$$" $(LOG) || (echo "Simulation did not pass"; exit 1)

lint:
	$(SIM) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
